// ==== common/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    // --------------------
    // widths
    // --------------------

    // every operand and result field is sized from this constant
    localparam int unsigned alu_data_width = 32;

    // the tag only has to tell in-flight requests apart, so 16 values are plenty
    localparam int unsigned alu_tag_width = 4;

    // --------------------
    // opcodes
    // --------------------

    // encodings 6 and 7 are spare and decode to a zero result in the datapath
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_sltu = 3'd5
    } alu_op_e;

    // --------------------
    // request and response
    // --------------------

    // one request word as it travels from upstream through the queue
    // it is 3 + 32 + 32 + 4 = 71 bits wide
    typedef struct packed {
        alu_op_e                    op;
        logic [alu_data_width-1:0]  a;
        logic [alu_data_width-1:0]  b;
        logic [alu_tag_width-1:0]   tag;
    } alu_req_t;

    // carry holds the adder carry out for add
    // for sub and sltu it holds the subtractor borrow out instead
    // logic ops always report zero here
    typedef struct packed {
        logic carry;
        logic zero;
    } alu_flags_t;

    // the response keeps the request tag so downstream can match it
    // it is 32 + 2 + 4 = 38 bits wide
    typedef struct packed {
        logic [alu_data_width-1:0]  result;
        alu_flags_t                 flags;
        logic [alu_tag_width-1:0]   tag;
    } alu_rsp_t;

endpackage : alu_pkg

`default_nettype wire

// ==== alu/ripple_carry_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ripple_carry_adder #(
    parameter int n = 32
) (
    input  wire  [n-1:0] a,
    input  wire  [n-1:0] b,
    input  wire          carry_in,
    output logic [n-1:0] sum,
    output logic         carry_out
);

    // carry[i] is the carry into bit i and carry[n] leaves the top bit
    logic [n:0] carry;

    assign carry[0] = carry_in;

    // --------------------
    // full adder cells
    // --------------------

    for (genvar i = 0; i < n; i++) begin : g_fa_cell
        // the sum bit is the odd parity of the three inputs
        assign sum[i] = a[i] ^ b[i] ^ carry[i];

        // carry out whenever at least two of the three inputs are set
        assign carry[i+1] = (a[i] & b[i]) |
                            (a[i] & carry[i]) |
                            (b[i] & carry[i]);
    end : g_fa_cell

    assign carry_out = carry[n];

endmodule : ripple_carry_adder

`default_nettype wire

// ==== alu/ripple_carry_subtraction.sv ====
`timescale 1ns/1ps
`default_nettype none

module ripple_carry_subtraction #(
    parameter int n = 32
) (
    input  wire  [n-1:0] a,
    input  wire  [n-1:0] b,
    input  wire          borrow_in,
    output logic [n-1:0] diff,
    output logic         borrow_out
);

    // borrow[i] is the borrow taken into bit i from below
    // borrow[n] is the borrow the top bit asks of the next word
    logic [n:0] borrow;

    assign borrow[0] = borrow_in;

    // --------------------
    // full subtractor cells
    // --------------------

    // per bit truth table for a - b - bin
    //   a b bin | d bout
    //   0 0  0  | 0  0
    //   0 0  1  | 1  1
    //   0 1  0  | 1  1
    //   0 1  1  | 0  1
    //   1 0  0  | 1  0
    //   1 0  1  | 0  0
    //   1 1  0  | 0  0
    //   1 1  1  | 1  1
    for (genvar i = 0; i < n; i++) begin : g_fs_cell
        // the difference bit has the same parity form as an adder sum
        assign diff[i] = a[i] ^ b[i] ^ borrow[i];

        // borrow when b exceeds a outright
        // or when the bits are equal and a borrow is already pending
        assign borrow[i+1] = (~a[i] & b[i]) |
                             (~(a[i] ^ b[i]) & borrow[i]);
    end : g_fs_cell

    // with a zero borrow in this is set exactly when b > a unsigned
    assign borrow_out = borrow[n];

endmodule : ripple_carry_subtraction

`default_nettype wire

// ==== alu/alu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_datapath
    import alu_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           issue,
    input  wire alu_req_t req,
    output logic          dp_valid,
    output alu_rsp_t      dp_rsp
);

    // --------------------
    // arithmetic units
    // --------------------

    logic [alu_data_width-1:0] sum;
    logic                      carry_out;
    logic [alu_data_width-1:0] diff;
    logic                      borrow_out;

    // next response word, registered below
    logic [alu_data_width-1:0] result;
    alu_flags_t                flags;
    alu_rsp_t                  rsp_next;

    // single word arithmetic only so the chain inputs are tied low
    ripple_carry_adder #(
        .n (alu_data_width)
    ) adder_inst (
        .a         (req.a),
        .b         (req.b),
        .carry_in  (1'b0),
        .sum       (sum),
        .carry_out (carry_out)
    );

    // the subtractor serves both op_sub and op_sltu
    // a < b unsigned is the same thing as a borrow out of a - b
    ripple_carry_subtraction #(
        .n (alu_data_width)
    ) subtractor_inst (
        .a          (req.a),
        .b          (req.b),
        .borrow_in  (1'b0),
        .diff       (diff),
        .borrow_out (borrow_out)
    );

    // --------------------
    // opcode decode
    // --------------------

    always_comb begin
        result      = '0;
        flags.carry = 1'b0;

        case (req.op)
            op_add: begin
                result      = sum;
                flags.carry = carry_out;
            end
            op_sub: begin
                result      = diff;
                flags.carry = borrow_out;
            end
            op_and: begin
                result = req.a & req.b;
            end
            op_or: begin
                result = req.a | req.b;
            end
            op_xor: begin
                result = req.a ^ req.b;
            end
            op_sltu: begin
                // the borrow lands in bit 0 and the upper bits stay zero
                result      = {{(alu_data_width-1){1'b0}}, borrow_out};
                flags.carry = borrow_out;
            end
            default: begin
                // spare encodings give a zero result with no carry
                result      = '0;
                flags.carry = 1'b0;
            end
        endcase

        // zero follows the selected result for every opcode
        flags.zero = (result == '0);

        rsp_next.result = result;
        rsp_next.flags  = flags;
        rsp_next.tag    = req.tag;
    end

    // --------------------
    // output register
    // --------------------

    // the valid bit is control state and starts low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
        end else begin
            dp_valid <= issue;
        end
    end

    // payload loads every cycle and is qualified by dp_valid
    // so back to back issues simply replace each other one per clock
    always_ff @(posedge clk) begin
        dp_rsp <= rsp_next;
    end

endmodule : alu_datapath

`default_nettype wire

// ==== alu/alu_result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_result_stage
    import alu_pkg::*;
#(
    parameter int rsp_credits = 2
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           dp_valid,
    input  wire alu_rsp_t dp_rsp,
    input  wire           rsp_credit,
    output logic          issue_ok,
    output logic          rsp_valid,
    output alu_rsp_t      rsp
);

    // downstream never returns more than it was given
    // so the counter only has to reach rsp_credits
    localparam int credit_w = $clog2(rsp_credits + 1);

    // --------------------
    // response buffer
    // --------------------

    // two entries are enough to cover the datapath register plus one stall
    alu_rsp_t buf_mem [2];
    logic     wr_ptr;
    logic     rd_ptr;
    logic [1:0] buf_count;

    logic [credit_w-1:0] credit_cnt;

    // an entry leaving this cycle frees its slot for the issue decision
    logic [1:0] occupancy;

    // the head goes out whenever there is both data and a credit to spend
    assign rsp_valid = (buf_count != 2'd0) && (credit_cnt != '0);
    assign rsp       = buf_mem[rd_ptr];

    // entries still held after this edge plus the one in the datapath register
    // must stay below two or the next issue could overflow the buffer
    assign occupancy = buf_count + {1'b0, dp_valid} - {1'b0, rsp_valid};
    assign issue_ok  = (occupancy < 2'd2);

    always_ff @(posedge clk) begin
        if (dp_valid) begin
            buf_mem[wr_ptr] <= dp_rsp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= 1'b0;
            rd_ptr    <= 1'b0;
            buf_count <= 2'd0;
        end else begin
            if (dp_valid) begin
                wr_ptr <= ~wr_ptr;
            end
            if (rsp_valid) begin
                rd_ptr <= ~rd_ptr;
            end
            buf_count <= occupancy;
        end
    end

    // --------------------
    // downstream credits
    // --------------------

    // each valid spends one credit and each returned pulse gives one back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= credit_w'(rsp_credits);
        end else begin
            credit_cnt <= credit_cnt
                        - {{(credit_w-1){1'b0}}, rsp_valid}
                        + {{(credit_w-1){1'b0}}, rsp_credit};
        end
    end

endmodule : alu_result_stage

`default_nettype wire

// ==== source/credit_request_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_request_queue
    import alu_pkg::*;
#(
    parameter int queue_depth = 4
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           req_valid,
    input  wire alu_req_t req,
    input  wire           issue_ok,
    output logic          head_valid,
    output alu_req_t      head,
    output logic          issue,
    output logic          req_credit
);

    // pointers need at least one bit even for a single entry queue
    localparam int ptr_w   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_w = $clog2(queue_depth + 1);

    // --------------------
    // storage
    // --------------------

    alu_req_t mem [queue_depth];

    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [count_w-1:0] count;

    logic full;
    logic push;

    assign full = (count == count_w'(queue_depth));

    // upstream spends a credit per request so it cannot overrun us
    // a stray write into a full queue is dropped rather than corrupting an entry
    assign push = req_valid && !full;

    // the head is visible the cycle after it was written
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

    // popping the head is the issue into the datapath
    assign issue = head_valid && issue_ok;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

    // --------------------
    // pointers and count
    // --------------------

    // the depth need not be a power of two so wrap explicitly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == ptr_w'(queue_depth - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end

            if (issue) begin
                if (rd_ptr == ptr_w'(queue_depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end

            count <= count
                   + {{(count_w-1){1'b0}}, push}
                   - {{(count_w-1){1'b0}}, issue};
        end
    end

    // --------------------
    // upstream credit return
    // --------------------

    // one pulse per freed slot, one cycle after the pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_credit <= 1'b0;
        end else begin
            req_credit <= issue;
        end
    end

endmodule : credit_request_queue

`default_nettype wire

// ==== source/credit_alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_alu_top
    import alu_pkg::*;
#(
    parameter int queue_depth = 4,
    parameter int rsp_credits = 2
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           req_valid,
    input  wire alu_req_t req,
    input  wire           rsp_credit,
    output logic          req_credit,
    output logic          rsp_valid,
    output alu_rsp_t      rsp
);

    // --------------------
    // internal paths
    // --------------------

    alu_req_t head;
    logic     issue;
    logic     issue_ok;
    logic     dp_valid;
    alu_rsp_t dp_rsp;

    // queue depth doubles as the upstream credit count
    // head_valid is left open here because issue already folds it in
    credit_request_queue #(
        .queue_depth (queue_depth)
    ) credit_request_queue_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .issue_ok   (issue_ok),
        .head_valid (),
        .head       (head),
        .issue      (issue),
        .req_credit (req_credit)
    );

    // the popped head goes straight into the one cycle datapath
    alu_datapath alu_datapath_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .req      (head),
        .dp_valid (dp_valid),
        .dp_rsp   (dp_rsp)
    );

    // the result stage throttles issue so the datapath never overruns it
    alu_result_stage #(
        .rsp_credits (rsp_credits)
    ) alu_result_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .dp_valid   (dp_valid),
        .dp_rsp     (dp_rsp),
        .rsp_credit (rsp_credit),
        .issue_ok   (issue_ok),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule : credit_alu_top

`default_nettype wire

// ==== test/alu_tb_vectors.svh ====
`ifndef alu_tb_vectors_svh
`define alu_tb_vectors_svh

// one row holds the opcode, both operands and the expected result and flags
// the flags literal is written as {carry, zero}
typedef struct packed {
    alu_op_e                   op;
    logic [alu_data_width-1:0] a;
    logic [alu_data_width-1:0] b;
    logic [alu_data_width-1:0] result;
    alu_flags_t                flags;
} vector_t;

localparam int num_vectors = 24;

string   vec_name [num_vectors];
vector_t vec_tab  [num_vectors];

task automatic set_vector(input int idx, input string name, input alu_op_e op,
                          input logic [alu_data_width-1:0] a,
                          input logic [alu_data_width-1:0] b,
                          input logic [alu_data_width-1:0] result,
                          input alu_flags_t flags);
    vec_name[idx] = name;
    vec_tab[idx]  = '{op: op, a: a, b: b, result: result, flags: flags};
endtask

task automatic load_vectors();
    // add wraps modulo 2^32 and carry marks a true sum above all ones
    set_vector(0,  "add_small",         op_add,  32'h00000005, 32'h00000007, 32'h0000000c, 2'b00);
    set_vector(1,  "add_ones_plus_one", op_add,  32'hffffffff, 32'h00000001, 32'h00000000, 2'b11);
    set_vector(2,  "add_top_carry",     op_add,  32'h80000001, 32'h80000000, 32'h00000001, 2'b10);
    set_vector(3,  "add_zero",          op_add,  32'h00000000, 32'h00000000, 32'h00000000, 2'b01);
    set_vector(4,  "add_mixed",         op_add,  32'h12345678, 32'h87654321, 32'h99999999, 2'b00);
    // carry on subtract is the borrow, set exactly when b > a unsigned
    set_vector(5,  "sub_basic",         op_sub,  32'h0000000a, 32'h00000003, 32'h00000007, 2'b00);
    set_vector(6,  "sub_equal",         op_sub,  32'hdeadbeef, 32'hdeadbeef, 32'h00000000, 2'b01);
    set_vector(7,  "sub_zero_minus_one", op_sub, 32'h00000000, 32'h00000001, 32'hffffffff, 2'b10);
    set_vector(8,  "sub_borrow_top",    op_sub,  32'h00000001, 32'h80000000, 32'h80000001, 2'b10);
    set_vector(9,  "sub_from_max",      op_sub,  32'hffffffff, 32'h00000001, 32'hfffffffe, 2'b00);
    // logic ops never carry and zero follows the result
    set_vector(10, "and_complement",    op_and,  32'ha5a5a5a5, 32'h5a5a5a5a, 32'h00000000, 2'b01);
    set_vector(11, "and_mask",          op_and,  32'hffff0000, 32'h12345678, 32'h12340000, 2'b00);
    set_vector(12, "and_ones",          op_and,  32'hffffffff, 32'hffffffff, 32'hffffffff, 2'b00);
    set_vector(13, "or_halves",         op_or,   32'hffff0000, 32'h0000ffff, 32'hffffffff, 2'b00);
    set_vector(14, "or_zero",           op_or,   32'h00000000, 32'h00000000, 32'h00000000, 2'b01);
    set_vector(15, "or_end_bits",       op_or,   32'h00000001, 32'h80000000, 32'h80000001, 2'b00);
    set_vector(16, "xor_same",          op_xor,  32'h13579bdf, 32'h13579bdf, 32'h00000000, 2'b01);
    set_vector(17, "xor_pattern",       op_xor,  32'hf0f0f0f0, 32'hff00ff00, 32'h0ff00ff0, 2'b00);
    set_vector(18, "xor_invert",        op_xor,  32'hffffffff, 32'h12345678, 32'hedcba987, 2'b00);
    // sltu gives 1 for a < b unsigned and carry copies it
    set_vector(19, "sltu_less",         op_sltu, 32'h00000001, 32'h00000002, 32'h00000001, 2'b10);
    set_vector(20, "sltu_greater",      op_sltu, 32'h00000002, 32'h00000001, 32'h00000000, 2'b01);
    set_vector(21, "sltu_equal",        op_sltu, 32'h00000007, 32'h00000007, 32'h00000000, 2'b01);
    set_vector(22, "sltu_top_bit",      op_sltu, 32'h7fffffff, 32'h80000000, 32'h00000001, 2'b10);
    set_vector(23, "sltu_zero_max",     op_sltu, 32'h00000000, 32'hffffffff, 32'h00000001, 2'b10);
endtask

`endif

// ==== test/alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_tb
    import alu_pkg::*;
;

    localparam int queue_depth = 4;
    localparam int rsp_credits = 2;

    `include "alu_tb_vectors.svh"

    // worst case allows every request a long stall plus reset and drain time
    localparam int cycle_limit = num_vectors * 40 + 100;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    alu_req_t req;
    logic     rsp_credit;
    logic     req_credit;
    logic     rsp_valid;
    alu_rsp_t rsp;

    // --------------------
    // scoreboard state
    // --------------------

    alu_rsp_t exp_q  [$];
    string    name_q [$];
    integer   seed;
    int       cycle;
    int       next_idx;
    int       up_credits;
    int       req_credit_pulses;
    int       received;
    int       rsp_credit_sent;
    int       rsp_credit_seen;
    int       data_errors;
    int       flag_errors;
    int       tag_errors;
    int       protocol_errors;
    bit       timed_out;

    credit_alu_top #(
        .queue_depth (queue_depth),
        .rsp_credits (rsp_credits)
    ) credit_alu_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .rsp_credit (rsp_credit),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    always #2 clk = ~clk;

    task automatic check_data(input string name, input logic [alu_data_width-1:0] exp,
                              input logic [alu_data_width-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s result expected %h actual %h", name, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t act);
        if (act !== exp) begin
            $display("FAIL %s flags expected %b actual %b", name, exp, act);
            flag_errors++;
        end
    endtask

    task automatic check_tag(input string name, input logic [alu_tag_width-1:0] exp,
                             input logic [alu_tag_width-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s tag expected %h actual %h", name, exp, act);
            tag_errors++;
        end
    endtask

    // reads the values the DUT held through the cycle that just ended
    task automatic sample_outputs();
        alu_rsp_t exp;
        string    name;
        if (req_credit === 1'b1) begin
            up_credits++;
            req_credit_pulses++;
            if (up_credits > queue_depth) begin
                $display("req_credit returned more credits than upstream ever spent");
                protocol_errors++;
            end
        end
        if (rsp_valid === 1'b1) begin
            received++;
            if (received > rsp_credits + rsp_credit_seen) begin
                $display("response %0d was sent without a downstream credit", received);
                protocol_errors++;
            end
            if (exp_q.size() == 0) begin
                $display("a response arrived while no request was outstanding");
                protocol_errors++;
            end else begin
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                check_data(name, exp.result, rsp.result);
                check_flags(name, exp.flags, rsp.flags);
                check_tag(name, exp.tag, rsp.tag);
            end
        end
        // a pulse only counts once the DUT has seen it at this edge
        if (rsp_credit === 1'b1) begin
            rsp_credit_seen++;
        end
    endtask

    task automatic drive_inputs();
        alu_req_t next_req;
        alu_rsp_t exp;
        int       rnd;
        if (next_idx < num_vectors && up_credits > 0) begin
            next_req.op  = vec_tab[next_idx].op;
            next_req.a   = vec_tab[next_idx].a;
            next_req.b   = vec_tab[next_idx].b;
            next_req.tag = alu_tag_width'(next_idx % 16);
            req_valid <= 1'b1;
            req       <= next_req;
            up_credits--;
            exp.result = vec_tab[next_idx].result;
            exp.flags  = vec_tab[next_idx].flags;
            exp.tag    = next_req.tag;
            exp_q.push_back(exp);
            name_q.push_back(vec_name[next_idx]);
            next_idx++;
        end else begin
            req_valid <= 1'b0;
        end
        // downstream hands back a credit about 40 percent of the time it owes one
        rnd = $random(seed);
        if (rsp_credit_sent < received && ($unsigned(rnd) % 100) < 40) begin
            rsp_credit <= 1'b1;
            rsp_credit_sent++;
        end else begin
            rsp_credit <= 1'b0;
        end
    endtask

    initial begin
        seed       = 91249;
        clk        = 1'b0;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_credit = 1'b0;
        up_credits = queue_depth;
        load_vectors();

        // ------------------
        // reset
        // ------------------
        repeat (16) begin
            @(posedge clk);
        end
        // both credit side outputs sit at their reset values before release
        if (rsp_valid !== 1'b0 || req_credit !== 1'b0) begin
            $display("rsp_valid or req_credit was not low at the end of reset");
            protocol_errors++;
        end
        rst_n <= 1'b1;

        // main loop runs until every response is back or the limit is hit
        while (received < num_vectors && !timed_out) begin
            @(posedge clk);
            cycle++;
            sample_outputs();
            drive_inputs();
            if (cycle >= cycle_limit) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            $display("timeout after %0d cycles with %0d of %0d responses received",
                     cycle, received, num_vectors);
            protocol_errors++;
        end else begin
            // a few idle cycles catch stray responses or late credit pulses
            repeat (4) begin
                @(posedge clk);
                sample_outputs();
                drive_inputs();
            end
            if (req_credit_pulses != num_vectors || up_credits != queue_depth) begin
                $display("upstream got %0d req_credit pulses for %0d requests",
                         req_credit_pulses, num_vectors);
                protocol_errors++;
            end
        end

        $display("errors: data %0d flags %0d tag %0d protocol %0d",
                 data_errors, flag_errors, tag_errors, protocol_errors);
        if (data_errors + flag_errors + tag_errors + protocol_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : alu_tb

`default_nettype wire

// ==== src.f ====
+incdir+test
common/alu_pkg.sv
alu/ripple_carry_adder.sv
alu/ripple_carry_subtraction.sv
alu/alu_datapath.sv
alu/alu_result_stage.sv
source/credit_request_queue.sv
source/credit_alu_top.sv
test/alu_tb.sv
